/* source/l2_config.svh */
// Sizes are fixed and consistent by hand; changing one needs the derived values edited as well
`ifndef L2_CONFIG_SVH
`define L2_CONFIG_SVH

// Client side
`define L2_ADDR_BITS   16
`define L2_WORD_BITS   32
`define L2_WORD_BYTES  4

// Line geometry
`define L2_LINE_WORDS  4
`define L2_LINE_BITS   128
`define L2_LINE_BYTES  16

// Address split: tag | set | word index | byte offset
`define L2_SET_BITS    4
`define L2_SET_COUNT   16
`define L2_OFFSET_BITS 4
`define L2_WIDX_BITS   2
`define L2_BYTE_BITS   2
`define L2_TAG_BITS    8

// Lines visited by the reset sweep and flush, two ways per set
`define L2_LINES_TOTAL 32

`endif

/* source/l2_pkg.sv */
// Address views assume the field widths of l2_config.svh and exactly two ways per set
`include "l2_config.svh"

package l2_pkg;

    // Controller states
    typedef enum logic [3:0] {
        ST_RESET,
        ST_RESET_WR,
        ST_IDLE,
        ST_CHECK_HIT,
        ST_TRANSLATE,
        ST_WAIT_GRANT,
        ST_WRITE_BUS,
        ST_WAIT_RESP,
        ST_CHECK_RESP,
        ST_SETUP_READ,
        ST_FLUSH_ADDR,
        ST_FLUSH_CHECK
    } ctrl_state_e;

    // Normal cached access
    typedef struct packed {
        logic [`L2_TAG_BITS-1:0]  tag;
        logic [`L2_SET_BITS-1:0]  set;
        logic [`L2_WIDX_BITS-1:0] widx;
        logic [`L2_BYTE_BITS-1:0] boff;
    } l2_cached_addr_t;

    // Direct line select, way in the lowest bit
    typedef struct packed {
        logic [`L2_ADDR_BITS-`L2_SET_BITS-2:0] unused;
        logic [`L2_SET_BITS-1:0]               set;
        logic                                  way;
    } l2_direct_addr_t;

    typedef union packed {
        l2_cached_addr_t cached;
        l2_direct_addr_t direct;
    } l2_addr_u;

endpackage

/* source/l2_tag_if.sv */
// Results follow a read or direct select by one cycle; writes use the way selected by that access
`timescale 1ns/100ps
`include "l2_config.svh"

interface l2_tag_if;

    // Controller to array
    logic                      re;
    logic                      direct;
    logic                      we;
    logic                      invalidate;
    l2_pkg::l2_addr_u          addr;
    logic [`L2_LINE_BITS-1:0]  wdata;
    logic [`L2_LINE_BYTES-1:0] wstrb;
    logic                      wdirty;

    // Array to controller, registered
    logic                      hit;
    logic [`L2_LINE_BITS-1:0]  rdata;
    logic [`L2_ADDR_BITS-1:0]  raddr;
    logic                      rvalid;
    logic                      rdirty;

    modport ctrl (
        output re, direct, we, invalidate, addr, wdata, wstrb, wdirty,
        input  hit, rdata, raddr, rvalid, rdirty
    );

    modport mem (
        input  re, direct, we, invalidate, addr, wdata, wstrb, wdirty,
        output hit, rdata, raddr, rvalid, rdirty
    );

endinterface

/* source/l2_tag_mem.sv */
// Two ways only with one LRU bit per set; valid flags are cleared by the controller's reset sweep
`timescale 1ns/100ps
`include "l2_config.svh"

module l2_tag_mem (
    input logic   i_clk,
    input logic   i_nrst,
    l2_tag_if.mem tag_if
);

    localparam int WAYS = 2;
    localparam int SETS = `L2_SET_COUNT;

    logic [`L2_TAG_BITS-1:0]  tag_mem   [SETS][WAYS];
    logic [`L2_LINE_BITS-1:0] data_mem  [SETS][WAYS];
    logic                     valid_mem [SETS][WAYS];
    logic                     dirty_mem [SETS][WAYS];

    // Per set, the way to evict next
    logic [SETS-1:0] lru;

    logic [`L2_SET_BITS-1:0] set_sel;
    logic [`L2_SET_BITS-1:0] set_q;
    logic                    way_sel;
    logic                    way_q;
    logic [WAYS-1:0]         way_hit;
    logic                    access;

    assign access  = tag_if.re || tag_if.direct;
    assign set_sel = tag_if.direct ? tag_if.addr.direct.set : tag_if.addr.cached.set;

    always_comb begin
        for (int w = 0; w < WAYS; w++) begin
            way_hit[w] = valid_mem[set_sel][w]
                      && (tag_mem[set_sel][w] == tag_if.addr.cached.tag);
        end
    end

    // Hit way first, LRU victim on a miss
    always_comb begin
        if (tag_if.direct) begin
            way_sel = tag_if.addr.direct.way;
        end else if (way_hit[1]) begin
            way_sel = 1'b1;
        end else if (way_hit[0]) begin
            way_sel = 1'b0;
        end else begin
            way_sel = lru[set_sel];
        end
    end

    // Selection and flags of the accessed line
    always_ff @(posedge i_clk or negedge i_nrst) begin
        if (!i_nrst) begin
            set_q         <= '0;
            way_q         <= 1'b0;
            tag_if.hit    <= 1'b0;
            tag_if.rvalid <= 1'b0;
            tag_if.rdirty <= 1'b0;
        end else if (access) begin
            set_q         <= set_sel;
            way_q         <= way_sel;
            tag_if.hit    <= tag_if.re && (|way_hit);
            tag_if.rvalid <= valid_mem[set_sel][way_sel];
            tag_if.rdirty <= dirty_mem[set_sel][way_sel];
        end
    end

    // Line read-out and array writes
    always_ff @(posedge i_clk) begin
        if (access) begin
            tag_if.rdata <= data_mem[set_sel][way_sel];
            tag_if.raddr <= {tag_mem[set_sel][way_sel], set_sel, {`L2_OFFSET_BITS{1'b0}}};
        end
        if (tag_if.we) begin
            for (int b = 0; b < `L2_LINE_BYTES; b++) begin
                if (tag_if.wstrb[b]) begin
                    data_mem[set_q][way_q][8*b +: 8] <= tag_if.wdata[8*b +: 8];
                end
            end
            tag_mem[set_q][way_q]   <= tag_if.addr.cached.tag;
            valid_mem[set_q][way_q] <= 1'b1;
            dirty_mem[set_q][way_q] <= tag_if.wdirty;
        end else if (tag_if.invalidate) begin
            valid_mem[set_q][way_q] <= 1'b0;
            dirty_mem[set_q][way_q] <= 1'b0;
        end
    end

    // The other way becomes the victim after use
    always_ff @(posedge i_clk or negedge i_nrst) begin
        if (!i_nrst) begin
            lru <= '0;
        end else if (tag_if.we && !tag_if.direct) begin
            lru[set_q] <= ~way_q;
        end else if (tag_if.re && (|way_hit)) begin
            lru[set_sel] <= ~way_sel;
        end
    end

endmodule

/* source/l2_ctrl.sv */
// One access in flight; requests are refused during the reset sweep and while a flush runs
`timescale 1ns/100ps
`include "l2_config.svh"

module l2_ctrl (
    input  logic                       i_clk,
    input  logic                       i_nrst,
    // Client port
    input  logic                       i_req_valid,
    input  logic                       i_req_write,
    input  logic [`L2_ADDR_BITS-1:0]   i_req_addr,
    input  logic [`L2_WORD_BITS-1:0]   i_req_wdata,
    input  logic [`L2_WORD_BYTES-1:0]  i_req_wstrb,
    output logic                       o_req_ready,
    output logic                       o_resp_valid,
    output logic [`L2_WORD_BITS-1:0]   o_resp_rdata,
    // Memory bus
    input  logic                       i_req_mem_ready,
    output logic                       o_req_mem_valid,
    output logic                       o_req_mem_write,
    output logic [`L2_ADDR_BITS-1:0]   o_req_mem_addr,
    output logic [`L2_LINE_BITS-1:0]   o_req_mem_data,
    input  logic                       i_mem_data_valid,
    input  logic [`L2_LINE_BITS-1:0]   i_mem_data,
    // Flush
    input  logic                       i_flush_valid,
    output logic                       o_flush_end,
    l2_tag_if.ctrl                     tag_if
);

    localparam int CNT_W = $clog2(`L2_LINES_TOTAL);
    localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(`L2_LINES_TOTAL - 1);

    l2_pkg::ctrl_state_e state;
    l2_pkg::l2_addr_u    req_addr;

    logic                       req_write;
    logic [`L2_WORD_BITS-1:0]   req_wdata;
    logic [`L2_WORD_BYTES-1:0]  req_wstrb;
    logic [CNT_W-1:0]           cnt;
    logic                       flush_pend;
    logic                       write_flush;
    logic                       mem_valid;
    logic                       mem_write;
    logic [`L2_ADDR_BITS-1:0]   mem_addr;
    logic [`L2_LINE_BITS-1:0]   mem_line;

    logic                       accept;
    logic                       flush_start;
    logic                       dirty_line;
    logic [`L2_WIDX_BITS-1:0]   widx;
    logic [`L2_WORD_BITS-1:0]   rd_word;
    logic [`L2_ADDR_BITS-1:0]   line_addr;
    logic [`L2_SET_BITS:0]      dir_next;
    logic [`L2_LINE_BITS-1:0]   fill_line;
    logic [`L2_LINE_BITS-1:0]   hit_wdata;
    logic [`L2_LINE_BYTES-1:0]  hit_wstrb;

    assign accept      = o_req_ready && i_req_valid;
    assign flush_start = (state == l2_pkg::ST_IDLE) && flush_pend;
    assign dirty_line  = tag_if.rvalid && tag_if.rdirty;
    assign widx        = req_addr.cached.widx;
    assign rd_word     = tag_if.rdata[widx*`L2_WORD_BITS +: `L2_WORD_BITS];
    assign line_addr   = {req_addr.cached.tag, req_addr.cached.set, {`L2_OFFSET_BITS{1'b0}}};

    // Next line in sweep order, way bit first
    assign dir_next = {req_addr.direct.set, req_addr.direct.way} + 1'b1;

    // Write hit touches only the addressed word
    assign hit_wdata = {`L2_LINE_WORDS{req_wdata}};
    assign hit_wstrb = {{(`L2_LINE_BYTES - `L2_WORD_BYTES){1'b0}}, req_wstrb}
                    << (widx * `L2_WORD_BYTES);

    // Fetched line with the pending write word merged in
    always_comb begin
        fill_line = mem_line;
        if (req_write) begin
            for (int b = 0; b < `L2_WORD_BYTES; b++) begin
                if (req_wstrb[b]) begin
                    fill_line[widx*`L2_WORD_BITS + 8*b +: 8] = req_wdata[8*b +: 8];
                end
            end
        end
    end

    // Array access and single-cycle strobes
    always_comb begin
        tag_if.re         = 1'b0;
        tag_if.direct     = 1'b0;
        tag_if.we         = 1'b0;
        tag_if.invalidate = 1'b0;
        tag_if.addr       = req_addr;
        tag_if.wdata      = fill_line;
        tag_if.wstrb      = '1;
        tag_if.wdirty     = req_write;
        o_req_ready       = 1'b0;
        o_resp_valid      = 1'b0;
        o_flush_end       = 1'b0;
        case (state)
            l2_pkg::ST_IDLE: begin
                o_req_ready = !flush_pend;
                tag_if.re   = !flush_pend && i_req_valid;
                tag_if.addr = i_req_addr;
            end
            l2_pkg::ST_CHECK_HIT: begin
                if (tag_if.hit) begin
                    o_resp_valid = 1'b1;
                    tag_if.we    = req_write;
                    tag_if.wdata = hit_wdata;
                    tag_if.wstrb = hit_wstrb;
                end
            end
            l2_pkg::ST_CHECK_RESP: begin
                tag_if.we    = 1'b1;
                o_resp_valid = req_write;
            end
            l2_pkg::ST_SETUP_READ: tag_if.re = 1'b1;
            l2_pkg::ST_RESET, l2_pkg::ST_FLUSH_ADDR: tag_if.direct = 1'b1;
            l2_pkg::ST_RESET_WR: tag_if.invalidate = 1'b1;
            l2_pkg::ST_FLUSH_CHECK: begin
                // Line data is already held in the read registers
                tag_if.invalidate = 1'b1;
                o_flush_end       = !dirty_line && (cnt == '0);
            end
            default: ;
        endcase
    end

    assign o_resp_rdata    = (o_resp_valid && !req_write) ? rd_word : '0;
    assign o_req_mem_valid = mem_valid;
    assign o_req_mem_write = mem_write;
    assign o_req_mem_addr  = mem_addr;
    assign o_req_mem_data  = mem_line;

    always_ff @(posedge i_clk or negedge i_nrst) begin
        if (!i_nrst) begin
            state       <= l2_pkg::ST_RESET;
            req_addr    <= '0;
            cnt         <= CNT_LAST;
            flush_pend  <= 1'b0;
            write_flush <= 1'b0;
            mem_valid   <= 1'b0;
            mem_write   <= 1'b0;
            mem_addr    <= '0;
        end else begin
            flush_pend <= i_flush_valid || (flush_pend && !flush_start);
            case (state)
                l2_pkg::ST_RESET: state <= l2_pkg::ST_RESET_WR;
                l2_pkg::ST_RESET_WR: begin
                    if (cnt == '0) begin
                        state <= l2_pkg::ST_IDLE;
                    end else begin
                        cnt   <= cnt - 1'b1;
                        {req_addr.direct.set, req_addr.direct.way} <= dir_next;
                        state <= l2_pkg::ST_RESET;
                    end
                end
                l2_pkg::ST_IDLE: begin
                    if (flush_start) begin
                        req_addr <= '0;
                        cnt      <= CNT_LAST;
                        state    <= l2_pkg::ST_FLUSH_ADDR;
                    end else if (accept) begin
                        req_addr <= i_req_addr;
                        state    <= l2_pkg::ST_CHECK_HIT;
                    end
                end
                l2_pkg::ST_CHECK_HIT: begin
                    state <= tag_if.hit ? l2_pkg::ST_IDLE : l2_pkg::ST_TRANSLATE;
                end
                l2_pkg::ST_TRANSLATE: begin
                    // Dirty victim goes out before the fetch
                    mem_valid <= 1'b1;
                    mem_write <= dirty_line;
                    mem_addr  <= dirty_line ? tag_if.raddr : line_addr;
                    state     <= l2_pkg::ST_WAIT_GRANT;
                end
                l2_pkg::ST_WAIT_GRANT: begin
                    if (i_req_mem_ready) begin
                        mem_valid <= 1'b0;
                        state     <= mem_write ? l2_pkg::ST_WRITE_BUS : l2_pkg::ST_WAIT_RESP;
                    end
                end
                l2_pkg::ST_WRITE_BUS: begin
                    if (i_mem_data_valid) begin
                        if (write_flush) begin
                            // Revisit the same line, now invalid, to advance
                            write_flush <= 1'b0;
                            state       <= l2_pkg::ST_FLUSH_ADDR;
                        end else begin
                            mem_valid <= 1'b1;
                            mem_write <= 1'b0;
                            mem_addr  <= line_addr;
                            state     <= l2_pkg::ST_WAIT_GRANT;
                        end
                    end
                end
                l2_pkg::ST_WAIT_RESP: begin
                    if (i_mem_data_valid) begin
                        state <= l2_pkg::ST_CHECK_RESP;
                    end
                end
                l2_pkg::ST_CHECK_RESP: begin
                    state <= req_write ? l2_pkg::ST_IDLE : l2_pkg::ST_SETUP_READ;
                end
                l2_pkg::ST_SETUP_READ: state <= l2_pkg::ST_CHECK_HIT;
                l2_pkg::ST_FLUSH_ADDR: state <= l2_pkg::ST_FLUSH_CHECK;
                l2_pkg::ST_FLUSH_CHECK: begin
                    if (dirty_line) begin
                        write_flush <= 1'b1;
                        mem_valid   <= 1'b1;
                        mem_write   <= 1'b1;
                        mem_addr    <= tag_if.raddr;
                        state       <= l2_pkg::ST_WAIT_GRANT;
                    end else if (cnt == '0) begin
                        state <= l2_pkg::ST_IDLE;
                    end else begin
                        cnt   <= cnt - 1'b1;
                        {req_addr.direct.set, req_addr.direct.way} <= dir_next;
                        state <= l2_pkg::ST_FLUSH_ADDR;
                    end
                end
                default: state <= l2_pkg::ST_IDLE;
            endcase
        end
    end

    // Request payload and bus line buffer
    always_ff @(posedge i_clk) begin
        if (accept) begin
            req_write <= i_req_write;
            req_wdata <= i_req_wdata;
            req_wstrb <= i_req_wstrb;
        end
        if ((state == l2_pkg::ST_TRANSLATE) || (state == l2_pkg::ST_FLUSH_CHECK)) begin
            mem_line <= tag_if.rdata;
        end else if ((state == l2_pkg::ST_WAIT_RESP) && i_mem_data_valid) begin
            mem_line <= i_mem_data;
        end
    end

endmodule

/* source/l2_cache.sv */
// Word-wide client port over a line-wide memory bus; the bus must answer every granted request
`timescale 1ns/100ps
`include "l2_config.svh"

module l2_cache (
    input  logic                       i_clk,
    input  logic                       i_nrst,
    // Client port
    input  logic                       i_req_valid,
    input  logic                       i_req_write,
    input  logic [`L2_ADDR_BITS-1:0]   i_req_addr,
    input  logic [`L2_WORD_BITS-1:0]   i_req_wdata,
    input  logic [`L2_WORD_BYTES-1:0]  i_req_wstrb,
    output logic                       o_req_ready,
    output logic                       o_resp_valid,
    output logic [`L2_WORD_BITS-1:0]   o_resp_rdata,
    // Memory bus
    input  logic                       i_req_mem_ready,
    output logic                       o_req_mem_valid,
    output logic                       o_req_mem_write,
    output logic [`L2_ADDR_BITS-1:0]   o_req_mem_addr,
    output logic [`L2_LINE_BITS-1:0]   o_req_mem_data,
    input  logic                       i_mem_data_valid,
    input  logic [`L2_LINE_BITS-1:0]   i_mem_data,
    // Flush
    input  logic                       i_flush_valid,
    output logic                       o_flush_end
);

    l2_tag_if tag_bus ();

    l2_ctrl u_ctrl (
        .i_clk            (i_clk),
        .i_nrst           (i_nrst),
        .i_req_valid      (i_req_valid),
        .i_req_write      (i_req_write),
        .i_req_addr       (i_req_addr),
        .i_req_wdata      (i_req_wdata),
        .i_req_wstrb      (i_req_wstrb),
        .o_req_ready      (o_req_ready),
        .o_resp_valid     (o_resp_valid),
        .o_resp_rdata     (o_resp_rdata),
        .i_req_mem_ready  (i_req_mem_ready),
        .o_req_mem_valid  (o_req_mem_valid),
        .o_req_mem_write  (o_req_mem_write),
        .o_req_mem_addr   (o_req_mem_addr),
        .o_req_mem_data   (o_req_mem_data),
        .i_mem_data_valid (i_mem_data_valid),
        .i_mem_data       (i_mem_data),
        .i_flush_valid    (i_flush_valid),
        .o_flush_end      (o_flush_end),
        .tag_if           (tag_bus.ctrl)
    );

    l2_tag_mem u_mem (
        .i_clk  (i_clk),
        .i_nrst (i_nrst),
        .tag_if (tag_bus.mem)
    );

endmodule

/* dv/l2_cache_asserts.sv */
// Observes the controller ports and state only; checks are off while reset is low
`timescale 1ns/100ps
`include "l2_config.svh"

module l2_cache_asserts (
    input logic                     i_clk,
    input logic                     i_nrst,
    input l2_pkg::ctrl_state_e      i_state,
    input logic                     i_req_ready,
    input logic                     i_resp_valid,
    input logic                     i_mem_valid,
    input logic                     i_mem_ready,
    input logic                     i_mem_write,
    input logic [`L2_ADDR_BITS-1:0] i_mem_addr,
    input logic [`L2_LINE_BITS-1:0] i_mem_data
);

    // Request fields hold until the bus grants
    a_mem_hold: assert property (@(posedge i_clk) disable iff (!i_nrst)
        (i_mem_valid && !i_mem_ready) |=> (i_mem_valid && $stable(i_mem_write)
            && $stable(i_mem_addr) && $stable(i_mem_data)))
        else $error("memory request changed before it was granted");

    a_mem_align: assert property (@(posedge i_clk) disable iff (!i_nrst)
        i_mem_valid |-> (i_mem_addr[`L2_OFFSET_BITS-1:0] == '0))
        else $error("memory address is not line aligned");

    a_resp_pulse: assert property (@(posedge i_clk) disable iff (!i_nrst)
        i_resp_valid |=> !i_resp_valid)
        else $error("response valid held for more than one cycle");

    a_ready_idle: assert property (@(posedge i_clk) disable iff (!i_nrst)
        (i_state != l2_pkg::ST_IDLE) |-> !i_req_ready)
        else $error("request ready outside the idle state");

endmodule

bind l2_ctrl l2_cache_asserts u_asserts (
    .i_clk        (i_clk),
    .i_nrst       (i_nrst),
    .i_state      (state),
    .i_req_ready  (o_req_ready),
    .i_resp_valid (o_resp_valid),
    .i_mem_valid  (o_req_mem_valid),
    .i_mem_ready  (i_req_mem_ready),
    .i_mem_write  (o_req_mem_write),
    .i_mem_addr   (o_req_mem_addr),
    .i_mem_data   (o_req_mem_data)
);

/* dv/l2_cache_tb.sv */
// Random accesses stay in sets 0 to 3 and set 9 to force evictions; bus delays come from a table
`timescale 1ns/100ps
`include "l2_config.svh"

module l2_cache_tb;

    localparam int CLK_PERIOD      = 4;
    localparam int SEED            = 88473;
    localparam int NUM_OPS         = 400;
    localparam int EVICT_OPS       = 6;
    localparam int OP_CYCLES       = 80;
    localparam int WIDX            = `L2_WIDX_BITS;
    localparam int LINE_IDX_BITS   = `L2_ADDR_BITS - `L2_OFFSET_BITS;
    localparam int WORD_IDX_BITS   = LINE_IDX_BITS + WIDX;
    localparam int LINES           = 1 << LINE_IDX_BITS;
    localparam int WATCHDOG_CYCLES = (NUM_OPS * 2 + EVICT_OPS + 1 + `L2_LINES_TOTAL) * OP_CYCLES
                                   + 2 * `L2_LINES_TOTAL + 16;

    logic                       i_clk = 1'b0;
    logic                       i_nrst;
    logic                       i_req_valid;
    logic                       i_req_write;
    logic [`L2_ADDR_BITS-1:0]   i_req_addr;
    logic [`L2_WORD_BITS-1:0]   i_req_wdata;
    logic [`L2_WORD_BYTES-1:0]  i_req_wstrb;
    logic                       o_req_ready;
    logic                       o_resp_valid;
    logic [`L2_WORD_BITS-1:0]   o_resp_rdata;
    logic                       i_req_mem_ready;
    logic                       o_req_mem_valid;
    logic                       o_req_mem_write;
    logic [`L2_ADDR_BITS-1:0]   o_req_mem_addr;
    logic [`L2_LINE_BITS-1:0]   o_req_mem_data;
    logic                       i_mem_data_valid;
    logic [`L2_LINE_BITS-1:0]   i_mem_data;
    logic                       i_flush_valid;
    logic                       o_flush_end;

    // Backing memory, word-level reference model and bus delay table
    logic [`L2_LINE_BITS-1:0]   mem_lines [LINES];
    logic [`L2_WORD_BITS-1:0]   model [LINES * `L2_LINE_WORDS];
    logic                       touched [LINES];
    logic [1:0]                 bus_delays [256];
    logic [7:0]                 delay_idx = 8'd0;
    int                         mem_reqs = 0;
    int                         mem_writes = 0;
    logic [31:0]                lfsr = 32'(SEED);

    l2_cache i_dut (.*);

    always #(CLK_PERIOD / 2) i_clk = ~i_clk;

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'hD000_0001) : (s >> 1);
    endfunction

    // One LFSR step per bit taken
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_step(lfsr);
            v    = {v[30:0], lfsr[0]};
        end
        return v;
    endfunction

    function automatic logic [31:0] fill_word(input logic [31:0] word);
        return (word * 32'h9E37_79B9) ^ 32'hC3A5_0000;
    endfunction

    function automatic logic [`L2_LINE_BITS-1:0] model_line(input logic [LINE_IDX_BITS-1:0] line);
        logic [`L2_LINE_BITS-1:0] v;
        for (int k = 0; k < `L2_LINE_WORDS; k++) begin
            v[k*`L2_WORD_BITS +: `L2_WORD_BITS] = model[{line, WIDX'(k)}];
        end
        return v;
    endfunction

    // Four tags over four sets, so each two-way set sees evictions
    function automatic l2_pkg::l2_addr_u random_addr();
        l2_pkg::l2_addr_u a;
        a             = '0;
        a.cached.tag  = 8'(rand_bits(2));
        a.cached.set  = 4'(rand_bits(2));
        a.cached.widx = 2'(rand_bits(2));
        return a;
    endfunction

    function automatic l2_pkg::l2_addr_u evict_addr(input int t);
        l2_pkg::l2_addr_u a;
        a             = '0;
        a.cached.tag  = 8'(32'h20 + t);
        a.cached.set  = 4'd9;
        a.cached.widx = 2'(rand_bits(2));
        return a;
    endfunction

    function automatic int bus_delay();
        int d;
        d         = int'(bus_delays[delay_idx]);
        delay_idx = delay_idx + 8'd1;
        return d;
    endfunction

    task automatic check(input logic [127:0] actual, input logic [127:0] expected,
                         input string what);
        if (actual !== expected) begin
            $display("CHECK FAILED at %0d ns: %s, got %0h, expected %0h",
                     $time, what, actual, expected);
            $display("Testbench failed");
            $fatal(1, "stopped at the first mismatch");
        end
    endtask

    // Starts and ends on a falling edge; latency counts cycles after the first one
    task automatic do_access(input logic wr, input l2_pkg::l2_addr_u addr,
                             input logic [31:0] wdata, input logic [3:0] wstrb,
                             output int latency);
        logic [WORD_IDX_BITS-1:0] word;
        logic [31:0]              expected;
        word        = {addr.cached.tag, addr.cached.set, addr.cached.widx};
        expected    = wr ? 32'd0 : model[word];
        i_req_valid = 1'b1;
        i_req_write = wr;
        i_req_addr  = addr;
        i_req_wdata = wdata;
        i_req_wstrb = wstrb;
        while (!o_req_ready) @(negedge i_clk);
        @(negedge i_clk);
        i_req_valid = 1'b0;
        latency     = 0;
        while (!o_resp_valid) begin
            @(negedge i_clk);
            latency++;
        end
        check(128'(o_resp_rdata), 128'(expected), "response data");
        if (wr) begin
            for (int b = 0; b < `L2_WORD_BYTES; b++) begin
                if (wstrb[b]) begin
                    model[word][8*b +: 8] = wdata[8*b +: 8];
                end
            end
        end
        touched[{addr.cached.tag, addr.cached.set}] = 1'b1;
        @(negedge i_clk);
        check(128'(o_resp_valid), 128'(0), "response longer than one cycle");
    endtask

    // Line was just used, so it must hit without bus traffic
    task automatic reread_hit(input l2_pkg::l2_addr_u addr);
        int latency;
        int req_before;
        req_before = mem_reqs;
        do_access(1'b0, addr, '0, '0, latency);
        check(128'(latency), 128'(0), "hit latency");
        check(128'(mem_reqs - req_before), 128'(0), "memory request on a hit");
    endtask

    // Memory bus responder with table-driven grant and data delays
    initial begin : mem_responder
        logic [LINE_IDX_BITS-1:0] line;
        logic                     wr;
        forever begin
            @(negedge i_clk);
            i_mem_data_valid = 1'b0;
            if (o_req_mem_valid) begin
                repeat (bus_delay()) @(negedge i_clk);
                i_req_mem_ready = 1'b1;
                line            = o_req_mem_addr[`L2_ADDR_BITS-1:`L2_OFFSET_BITS];
                wr              = o_req_mem_write;
                mem_reqs++;
                if (wr) begin
                    mem_lines[line] = o_req_mem_data;
                    mem_writes++;
                end
                @(negedge i_clk);
                i_req_mem_ready = 1'b0;
                repeat (bus_delay()) @(negedge i_clk);
                i_mem_data_valid = 1'b1;
                i_mem_data       = wr ? '0 : mem_lines[line];
            end
        end
    end

    initial begin : watchdog
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("Timeout: the DUT stopped responding within %0d cycles", WATCHDOG_CYCLES);
        $display("Testbench failed");
        $fatal(1, "watchdog expired");
    end

    initial begin : stimulus
        l2_pkg::l2_addr_u addr;
        int               latency;
        int               sweep;
        int               wb_before;
        int               req_before;
        i_nrst           = 1'b0;
        i_req_valid      = 1'b0;
        i_req_write      = 1'b0;
        i_req_addr       = '0;
        i_req_wdata      = '0;
        i_req_wstrb      = '0;
        i_req_mem_ready  = 1'b0;
        i_mem_data_valid = 1'b0;
        i_mem_data       = '0;
        i_flush_valid    = 1'b0;
        for (int l = 0; l < LINES; l++) begin
            touched[l] = 1'b0;
            for (int k = 0; k < `L2_LINE_WORDS; k++) begin
                model[WORD_IDX_BITS'(l * `L2_LINE_WORDS + k)] =
                    fill_word(32'(l * `L2_LINE_WORDS + k));
            end
            mem_lines[l] = model_line(LINE_IDX_BITS'(l));
        end
        for (int d = 0; d < 256; d++) begin
            bus_delays[d] = 2'(rand_bits(2));
        end
        repeat (2) @(negedge i_clk);
        i_nrst = 1'b1;

        // Reset sweep, two cycles per line with all outputs quiet
        sweep = 0;
        while (!o_req_ready) begin
            check(128'({o_resp_valid, o_req_mem_valid, o_flush_end}), 128'(0),
                  "control output active during reset sweep");
            sweep++;
            @(negedge i_clk);
        end
        check(128'(sweep), 128'(2 * `L2_LINES_TOTAL), "reset sweep length");

        for (int n = 0; n < NUM_OPS; n++) begin
            addr = random_addr();
            do_access(1'(rand_bits(1)), addr, rand_bits(32), 4'(rand_bits(4)), latency);
            if (rand_bits(2) == 32'd0) begin
                reread_hit(addr);
            end
        end

        // Three tags through one fresh set, LRU gives four write-backs
        wb_before = mem_writes;
        for (int n = 0; n < EVICT_OPS; n++) begin
            do_access(1'b1, evict_addr(n % 3), rand_bits(32), 4'hF, latency);
        end
        check(128'(mem_writes - wb_before), 128'(4), "write-backs while cycling three tags");
        addr = evict_addr(0);
        check(mem_lines[{addr.cached.tag, addr.cached.set}],
              model_line({addr.cached.tag, addr.cached.set}), "evicted line in memory");

        i_flush_valid = 1'b1;
        @(negedge i_clk);
        i_flush_valid = 1'b0;
        while (!o_flush_end) @(negedge i_clk);
        for (int n = 0; n < 4; n++) begin
            @(negedge i_clk);
            check(128'(o_flush_end), 128'(0), "second flush end pulse");
        end
        check(128'(o_req_ready), 128'(1), "request ready after flush");
        for (int l = 0; l < LINES; l++) begin
            if (touched[l]) begin
                check(mem_lines[l], model_line(LINE_IDX_BITS'(l)), "memory line after flush");
            end
        end

        // Line cached before the flush must come from memory again
        req_before = mem_reqs;
        do_access(1'b0, evict_addr(2), '0, '0, latency);
        check(128'(mem_reqs - req_before), 128'(1), "memory reads for a flushed line");

        $display("Testbench passed");
        $finish;
    end

endmodule

/* sources.f */
+incdir+source
source/l2_pkg.sv
source/l2_tag_if.sv
source/l2_tag_mem.sv
source/l2_ctrl.sv
source/l2_cache.sv
dv/l2_cache_asserts.sv
dv/l2_cache_tb.sv

/* run.sh */
#!/bin/sh
verilator --binary --timing --assert -Wno-fatal -f sources.f \
    --top-module l2_cache_tb -o l2_cache_sim || exit 1
out=$(./obj_dir/l2_cache_sim)
echo "$out"
echo "$out" | grep -q "Testbench passed" && exit 0 || exit 1
